//--- src.f
design/configure_pkg.sv
design/wires_pkg.sv
design/regfile_if.sv
design/register_file.sv
design/decoder.sv
design/alu.sv
design/control.sv
design/cpu.sv
testbench/cpu_tb.sv

//--- Makefile
# Verilator build and run for the cpu testbench

VERILATOR ?= verilator
TOP ?= cpu_tb
FILELIST ?= src.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert --timescale 1ns/1ps -j 0

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || (cat $(LOG); exit 1)
	@cat $(LOG)
	@if grep -q "Some tests failed" $(LOG); then \
		echo "simulation reported failure, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- testbench/cpu_tb.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_tb
  import wires_pkg::*;
();

  logic clock;
  logic reset;
  logic [31:0] imem_addr;
  logic imem_req;
  logic [31:0] imem_rdata;
  logic [31:0] dmem_addr;
  logic [31:0] dmem_wdata;
  logic dmem_re;
  logic dmem_we;
  logic [31:0] dmem_rdata;
  logic halted;

  logic [31:0] imem [1024];
  logic [31:0] dmem [1024];
  logic [31:0] model_imem [1024];
  logic [31:0] model_dmem [1024];
  logic [31:0] prog [$];
  logic [31:0] exp_addr [$];
  logic [31:0] exp_data [$];
  logic [31:0] exp_fetch [$];
  logic [31:0] exp_load [$];

  // funct fields per op in alu op table order
  logic [2:0] reg_f3 [10] = '{3'd0, 3'd0, 3'd7, 3'd6, 3'd4, 3'd2, 3'd3, 3'd1, 3'd5, 3'd5};
  logic [6:0] reg_f7 [10] = '{7'h00, 7'h20, 7'h00, 7'h00, 7'h00, 7'h00, 7'h00, 7'h00,
                              7'h00, 7'h20};
  logic [2:0] imm_f3 [9] = '{3'd0, 3'd7, 3'd6, 3'd4, 3'd2, 3'd3, 3'd1, 3'd5, 3'd5};
  logic [6:0] imm_f7 [9] = '{7'h00, 7'h00, 7'h00, 7'h00, 7'h00, 7'h00, 7'h00, 7'h00, 7'h20};

  logic i_take;
  logic r_take;
  logic w_take;
  logic [31:0] i_addr;
  logic [31:0] d_addr;
  logic [31:0] d_wdata;
  logic [31:0] exp_a;
  logic [31:0] exp_d;
  int errors = 0;
  int tests = 0;
  int failed = 0;
  int stores_checked = 0;

  cpu dut_i (
    .clock(clock),
    .reset(reset),
    .imem_addr(imem_addr),
    .imem_req(imem_req),
    .imem_rdata(imem_rdata),
    .dmem_addr(dmem_addr),
    .dmem_wdata(dmem_wdata),
    .dmem_re(dmem_re),
    .dmem_we(dmem_we),
    .dmem_rdata(dmem_rdata),
    .halted(halted)
  );

  initial begin
    clock = 1'b0;
    forever #50 clock = ~clock;
  end

  // one cycle latency memories with strobes sampled mid cycle
  always begin
    @(negedge clock);
    i_take = imem_req === 1'b1;
    r_take = dmem_re === 1'b1;
    w_take = dmem_we === 1'b1;
    i_addr = imem_addr;
    d_addr = dmem_addr;
    d_wdata = dmem_wdata;
    @(posedge clock);
    #5;
    if (i_take) imem_rdata = imem[i_addr[11:2]];
    if (w_take) dmem[d_addr[11:2]] = d_wdata;
    if (r_take) dmem_rdata = dmem[d_addr[11:2]];
  end

  // bus checker against the model's access lists
  always @(negedge clock) begin
    if (reset === 1'b0 && imem_req === 1'b1) begin
      assert (exp_fetch.size() != 0) else begin
        $display("unexpected fetch from %h at %0t", imem_addr, $time);
        errors++;
      end
      if (exp_fetch.size() != 0) begin
        exp_a = exp_fetch.pop_front();
        assert (imem_addr == exp_a) else begin
          $display("Mismatch at %0t: fetch from %h, expected %h", $time, imem_addr, exp_a);
          errors++;
        end
      end
    end
    if (reset === 1'b0 && dmem_re === 1'b1) begin
      assert (exp_load.size() != 0) else begin
        $display("unexpected load from %h at %0t", dmem_addr, $time);
        errors++;
      end
      if (exp_load.size() != 0) begin
        exp_a = exp_load.pop_front();
        assert (dmem_addr == exp_a) else begin
          $display("Mismatch at %0t: load from %h, expected %h", $time, dmem_addr, exp_a);
          errors++;
        end
      end
    end
    if (reset === 1'b0 && dmem_we === 1'b1) begin
      assert (exp_addr.size() != 0) else begin
        $display("unexpected store of %h to %h at %0t", dmem_wdata, dmem_addr, $time);
        errors++;
      end
      if (exp_addr.size() != 0) begin
        exp_a = exp_addr.pop_front();
        exp_d = exp_data.pop_front();
        stores_checked++;
        assert (dmem_addr == exp_a && dmem_wdata == exp_d) else begin
          $display("Mismatch at %0t: store %h to %h, expected %h to %h",
                   $time, dmem_wdata, dmem_addr, exp_d, exp_a);
          errors++;
        end
      end
    end
    if (reset === 1'b0 && halted === 1'b1) begin
      assert (!(imem_req || dmem_re || dmem_we)) else begin
        $display("memory strobe seen at %0t after the core halted", $time);
        errors++;
      end
    end
  end

  function automatic logic [31:0] r_format(input logic [6:0] f7, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3,
                                           input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, op_reg};
  endfunction

  function automatic logic [31:0] i_format(input logic [11:0] imm, input logic [4:0] rs1,
                                           input logic [2:0] f3, input logic [4:0] rd,
                                           input logic [6:0] op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic logic [31:0] s_format(input logic [11:0] imm, input logic [4:0] rs2,
                                           input logic [4:0] rs1);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], op_store};
  endfunction

  function automatic logic [31:0] b_format(input int off, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3);
    logic [12:0] o;
    o = 13'(off);
    return {o[12], o[10:5], rs2, rs1, f3, o[4:1], o[11], op_branch};
  endfunction

  function automatic logic [31:0] u_format(input logic [19:0] imm, input logic [4:0] rd);
    return {imm, rd, op_lui};
  endfunction

  function automatic logic [31:0] j_format(input int off, input logic [4:0] rd);
    logic [20:0] o;
    o = 21'(off);
    return {o[20], o[10:1], o[11], o[19:12], rd, op_jal};
  endfunction

  function automatic logic [31:0] ebreak_word();
    return i_format(12'd1, 5'd0, 3'd0, 5'd0, op_system);
  endfunction

  task automatic emit(input logic [31:0] w);
    prog.push_back(w);
  endtask

  // lui then addi with the upper part rounded for the low half sign
  task automatic set_reg(input logic [4:0] rd, input logic [31:0] v);
    logic [31:0] hi;
    hi = v + 32'h800;
    emit(u_format(hi[31:12], rd));
    emit(i_format(v[11:0], rd, 3'b000, rd, op_imm));
  endtask

  task automatic reg_op(input int k, input logic [4:0] rd, input logic [4:0] rs1,
                        input logic [4:0] rs2);
    emit(r_format(reg_f7[k], rs2, rs1, reg_f3[k], rd));
  endtask

  task automatic imm_op(input int k, input logic [4:0] rd, input logic [4:0] rs1,
                        input logic [11:0] imm);
    logic [11:0] field;
    field = imm;
    if (imm_f3[k] == 3'd1 || imm_f3[k] == 3'd5) field = {imm_f7[k], imm[4:0]}; // shamt
    emit(i_format(field, rs1, imm_f3[k], rd, op_imm));
  endtask

  task automatic store_word(input logic [4:0] rs2, input logic [4:0] rs1,
                            input logic [11:0] off);
    emit(s_format(off, rs2, rs1));
  endtask

  // illegal opcodes in imem and address tagged words in dmem
  task automatic new_program();
    logic [9:0] idx;
    prog.delete();
    for (int i = 0; i < 1024; i++) begin
      idx = 10'(i);
      imem[i] = {idx, ~idx, 5'd0, 7'h7f};
      dmem[i] = {idx, 6'h15, ~idx, 6'h2a};
    end
  endtask

  function automatic logic [31:0] compute_op(input logic [2:0] f3, input logic alt,
                                             input logic [31:0] a, input logic [31:0] b);
    logic [31:0] r;
    case (f3)
      3'd0: r = alt ? a - b : a + b;
      3'd1: r = a << b[4:0];
      3'd2: r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      3'd3: r = (a < b) ? 32'd1 : 32'd0;
      3'd4: r = a ^ b;
      3'd5: begin
        if (alt) r = $signed(a) >>> b[4:0];
        else r = a >> b[4:0];
      end
      3'd6: r = a | b;
      default: r = a & b;
    endcase
    return r;
  endfunction

  // instruction set model returning the executed instruction count
  function automatic int run_model();
    logic [31:0] x [32];
    logic [31:0] pc;
    logic [31:0] npc;
    logic [31:0] w;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] addr;
    logic [31:0] imm_i;
    logic [31:0] imm_s;
    logic [31:0] imm_b;
    logic [31:0] imm_j;
    logic [4:0] rd;
    logic [2:0] f3;
    logic [6:0] f7;
    logic take;
    logic done;
    int count;
    for (int k = 0; k < 32; k++) x[k] = '0;
    pc = '0;
    count = 0;
    done = 1'b0;
    while (!done && count < 2000) begin
      w = model_imem[pc[11:2]];
      rd = w[11:7];
      f3 = w[14:12];
      f7 = w[31:25];
      a = x[w[19:15]];
      b = x[w[24:20]];
      imm_i = {{20{w[31]}}, w[31:20]};
      imm_s = {{20{w[31]}}, w[31:25], w[11:7]};
      imm_b = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
      imm_j = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
      npc = pc + 32'd4;
      count++;
      exp_fetch.push_back(pc);
      case (w[6:0])
        op_reg: begin
          if (f7 != 7'h00 && !(f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5))) done = 1'b1;
          else x[rd] = compute_op(f3, f7[5], a, b);
        end
        op_imm: begin
          if ((f3 == 3'd1 && f7 != 7'h00) || (f3 == 3'd5 && f7 != 7'h00 && f7 != 7'h20))
            done = 1'b1;
          else
            x[rd] = compute_op(f3, f3 == 3'd5 && f7[5], a, imm_i);
        end
        op_lui: x[rd] = {w[31:12], 12'b0};
        op_load: begin
          addr = a + imm_i;
          if (f3 != 3'b010) begin
            done = 1'b1;
          end else begin
            x[rd] = model_dmem[addr[11:2]];
            exp_load.push_back(addr);
          end
        end
        op_store: begin
          addr = a + imm_s;
          if (f3 != 3'b010) begin
            done = 1'b1;
          end else begin
            model_dmem[addr[11:2]] = b;
            exp_addr.push_back(addr);
            exp_data.push_back(b);
          end
        end
        op_branch: begin
          take = 1'b0;
          case (f3)
            3'd0: take = a == b;
            3'd1: take = a != b;
            3'd4: take = $signed(a) < $signed(b);
            3'd5: take = $signed(a) >= $signed(b);
            default: done = 1'b1;
          endcase
          if (take) npc = pc + imm_b;
        end
        op_jal: begin
          x[rd] = pc + 32'd4;
          npc = pc + imm_j;
        end
        default: done = 1'b1; // ebreak and anything unsupported
      endcase
      x[0] = '0;
      pc = npc;
    end
    return count;
  endfunction

  task automatic run_test(input string name);
    int n;
    int limit;
    int cycles;
    int errs_before;
    errs_before = errors;
    for (int k = 0; k < prog.size(); k++) imem[k] = prog[k];
    exp_addr.delete();
    exp_data.delete();
    exp_fetch.delete();
    exp_load.delete();
    model_imem = imem;
    model_dmem = dmem;
    n = run_model();
    limit = 5 * n + 50;
    @(posedge clock);
    #5;
    reset = 1'b1;
    repeat (2) @(posedge clock);
    #5;
    reset = 1'b0;
    cycles = 0;
    while (halted !== 1'b1) begin
      @(negedge clock);
      cycles++;
      if (cycles > limit) begin
        $display("timeout in test %s: core did not halt within %0d cycles", name, limit);
        $display("Some tests failed");
        $finish;
      end
    end
    // five cycles per instruction after the first fetch edge
    assert (cycles == 5 * n + 2) else begin
      $display("Mismatch at %0t: test %s halted after %0d cycles, expected %0d",
               $time, name, cycles, 5 * n + 2);
      errors++;
    end
    repeat (20) @(negedge clock); // quiet period after halt
    @(posedge clock);
    assert (exp_addr.size() == 0) else begin
      $display("test %s: %0d expected stores are missing", name, exp_addr.size());
      errors++;
    end
    tests++;
    if (errors != errs_before) failed++;
    $display("test %0d %s: %s", tests, name, (errors == errs_before) ? "ok" : "FAILED");
  endtask

  initial begin
    int r;
    int k;
    int c;
    int loop_pc;
    logic [4:0] ra;
    logic [4:0] rb;
    logic [4:0] rc;
    void'($urandom(32'h1c4589a2));
    reset = 1'b1;
    imem_rdata = '0;
    dmem_rdata = '0;

    new_program();
    for (r = 0; r < 2; r++) begin
      set_reg(5'd1, (r == 0) ? $urandom : ($urandom | 32'h8000_0000)); // negative vs positive
      set_reg(5'd2, (r == 0) ? $urandom : ($urandom & 32'h7fff_ffff));
      for (k = 0; k < 10; k++) begin
        reg_op(k, 5'd3, 5'd1, 5'd2);
        store_word(5'd3, 5'd0, 12'(256 + 40 * r + 4 * k));
      end
    end
    emit(ebreak_word());
    run_test("register alu ops");

    new_program();
    for (r = 0; r < 2; r++) begin
      set_reg(5'd1, $urandom);
      for (k = 0; k < 9; k++) begin
        imm_op(k, 5'd3, 5'd1, 12'($urandom));
        store_word(5'd3, 5'd0, 12'(512 + 40 * r + 4 * k));
      end
    end
    emit(u_format(20'($urandom), 5'd4));
    store_word(5'd4, 5'd0, 12'h300);
    emit(ebreak_word());
    run_test("immediate ops and lui");

    new_program();
    for (k = 0; k < 8; k++) dmem[64 + k] = $urandom; // words at 0x100
    emit(i_format(12'h100, 5'd0, 3'b000, 5'd6, op_imm));
    for (k = 0; k < 8; k++) begin
      emit(i_format(12'(4 * k), 5'd6, 3'b010, 5'd5, op_load));
      imm_op(0, 5'd5, 5'd5, 12'($urandom));
      store_word(5'd5, 5'd6, 12'(256 + 4 * k));
    end
    emit(ebreak_word());
    run_test("load store round trip");

    new_program();
    emit(i_format(12'd0, 5'd0, 3'b000, 5'd1, op_imm));
    emit(i_format(12'd5, 5'd0, 3'b000, 5'd2, op_imm));
    loop_pc = 4 * prog.size();
    emit(i_format(12'd1, 5'd1, 3'b000, 5'd1, op_imm));
    store_word(5'd1, 5'd0, 12'h400);
    emit(b_format(loop_pc - 4 * prog.size(), 5'd2, 5'd1, 3'b001)); // bne back to loop
    emit(b_format(8, 5'd1, 5'd2, 3'b100)); // blt not taken
    store_word(5'd1, 5'd0, 12'h404);
    emit(b_format(8, 5'd2, 5'd1, 3'b101)); // bge taken
    store_word(5'd0, 5'd0, 12'h408);
    store_word(5'd2, 5'd0, 12'h40c);
    emit(i_format(12'hffd, 5'd0, 3'b000, 5'd4, op_imm));
    emit(b_format(8, 5'd1, 5'd4, 3'b100)); // signed -3 < 5
    store_word(5'd4, 5'd0, 12'h410);
    emit(b_format(8, 5'd1, 5'd4, 3'b101));
    store_word(5'd4, 5'd0, 12'h414);
    emit(j_format(8, 5'd3));
    store_word(5'd2, 5'd0, 12'h418);
    store_word(5'd3, 5'd0, 12'h41c); // link value
    emit(ebreak_word());
    run_test("control flow");

    new_program();
    set_reg(5'd1, $urandom | 32'd1);
    emit(i_format(12'd123, 5'd0, 3'b000, 5'd0, op_imm));
    emit(u_format(20'habcde, 5'd0));
    reg_op(0, 5'd0, 5'd1, 5'd1);
    store_word(5'd0, 5'd0, 12'h500);
    emit(ebreak_word());
    store_word(5'd1, 5'd0, 12'h504); // never reached
    run_test("x0 and halt");

    new_program();
    for (k = 1; k < 8; k++) set_reg(5'(k), $urandom);
    for (k = 0; k < 40; k++) begin
      c = $urandom_range(2, 0);
      ra = 5'($urandom_range(7, 0));
      rb = 5'($urandom_range(7, 0));
      rc = 5'($urandom_range(7, 0));
      case (c)
        0: reg_op($urandom_range(9, 0), ra, rb, rc);
        1: imm_op($urandom_range(8, 0), ra, rb, 12'($urandom));
        default: store_word(rc, 5'd0, 12'(1536 + 4 * $urandom_range(127, 0)));
      endcase
    end
    emit(ebreak_word());
    run_test("random program");

    $display("tests run %0d, failed %0d, stores checked %0d, errors %0d",
             tests, failed, stores_checked, errors);
    if (failed == 0 && errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- design/cpu.sv
`timescale 1ns/1ps
`default_nettype none

module cpu
  import configure_pkg::*;
  import wires_pkg::*;
(
  input logic clock,
  input logic reset,
  output logic [xlen-1:0] imem_addr,
  output logic imem_req,
  input logic [xlen-1:0] imem_rdata,
  output logic [xlen-1:0] dmem_addr,
  output logic [xlen-1:0] dmem_wdata,
  output logic dmem_re,
  output logic dmem_we,
  input logic [xlen-1:0] dmem_rdata,
  output logic halted
);

  instr_word_t instr;
  logic [alu_op_width-1:0] alu_op;
  logic [alu_op_width-1:0] alu_op_sel;
  logic [br_cond_width-1:0] br_cond;
  logic [br_cond_width-1:0] br_cond_sel;
  logic [xlen-1:0] imm;
  logic [reg_addr_width-1:0] rs1;
  logic [reg_addr_width-1:0] rs2;
  logic [reg_addr_width-1:0] rd;
  logic is_load;
  logic is_store;
  logic is_branch;
  logic is_jal;
  logic is_lui;
  logic use_imm;
  logic is_halt;
  logic illegal;
  logic [xlen-1:0] operand_a;
  logic [xlen-1:0] operand_b;
  logic [xlen-1:0] result;
  logic taken;

  regfile_if rf_if ();

  control control_i (
    .clock(clock),
    .reset(reset),
    .rf(rf_if),
    .instr(instr),
    .alu_op(alu_op),
    .br_cond(br_cond),
    .imm(imm),
    .rs1(rs1),
    .rs2(rs2),
    .rd(rd),
    .is_load(is_load),
    .is_store(is_store),
    .is_branch(is_branch),
    .is_jal(is_jal),
    .is_lui(is_lui),
    .use_imm(use_imm),
    .is_halt(is_halt),
    .illegal(illegal),
    .operand_a(operand_a),
    .operand_b(operand_b),
    .alu_op_sel(alu_op_sel),
    .br_cond_sel(br_cond_sel),
    .result(result),
    .taken(taken),
    .imem_addr(imem_addr),
    .imem_req(imem_req),
    .imem_rdata(imem_rdata),
    .dmem_addr(dmem_addr),
    .dmem_wdata(dmem_wdata),
    .dmem_re(dmem_re),
    .dmem_we(dmem_we),
    .dmem_rdata(dmem_rdata),
    .halted(halted)
  );

  decoder decoder_i (
    .instr(instr),
    .alu_op(alu_op),
    .br_cond(br_cond),
    .imm(imm),
    .rs1(rs1),
    .rs2(rs2),
    .rd(rd),
    .is_load(is_load),
    .is_store(is_store),
    .is_branch(is_branch),
    .is_jal(is_jal),
    .is_lui(is_lui),
    .use_imm(use_imm),
    .is_halt(is_halt),
    .illegal(illegal)
  );

  alu alu_i (
    .alu_op(alu_op_sel),
    .br_cond(br_cond_sel),
    .operand_a(operand_a),
    .operand_b(operand_b),
    .result(result),
    .taken(taken)
  );

  register_file register_file_i (
    .clock(clock),
    .reset(reset),
    .rf(rf_if)
  );

endmodule

`default_nettype wire

//--- design/control.sv
`timescale 1ns/1ps
`default_nettype none

module control
  import configure_pkg::*;
  import wires_pkg::*;
(
  input logic clock,
  input logic reset,
  regfile_if.core rf,
  output instr_word_t instr,
  input logic [alu_op_width-1:0] alu_op,
  input logic [br_cond_width-1:0] br_cond,
  input logic [xlen-1:0] imm,
  input logic [reg_addr_width-1:0] rs1,
  input logic [reg_addr_width-1:0] rs2,
  input logic [reg_addr_width-1:0] rd,
  input logic is_load,
  input logic is_store,
  input logic is_branch,
  input logic is_jal,
  input logic is_lui,
  input logic use_imm,
  input logic is_halt,
  input logic illegal,
  output logic [xlen-1:0] operand_a,
  output logic [xlen-1:0] operand_b,
  output logic [alu_op_width-1:0] alu_op_sel,
  output logic [br_cond_width-1:0] br_cond_sel,
  input logic [xlen-1:0] result,
  input logic taken,
  output logic [xlen-1:0] imem_addr,
  output logic imem_req,
  input logic [xlen-1:0] imem_rdata,
  output logic [xlen-1:0] dmem_addr,
  output logic [xlen-1:0] dmem_wdata,
  output logic dmem_re,
  output logic dmem_we,
  input logic [xlen-1:0] dmem_rdata,
  output logic halted
);

  logic [state_width-1:0] state;
  logic [xlen-1:0] pc;
  instr_word_t ir;
  instr_word_t fetched;
  logic [xlen-1:0] rs1_q;
  logic [xlen-1:0] rs2_q;
  logic [xlen-1:0] result_q;
  logic [xlen-1:0] pc_plus4;
  logic [xlen-1:0] branch_target;
  logic [xlen-1:0] next_pc;
  logic wb_en;

  always_ff @(posedge clock) begin
    if (reset) begin
      state <= st_fetch;
      pc <= reset_vector;
      imem_req <= 1'b0;
      halted <= 1'b0;
    end else begin
      case (state)
        st_fetch: begin
          if (imem_req) begin
            imem_req <= 1'b0;
            state <= st_decode;
          end else if (!halted) begin
            imem_req <= 1'b1; // first fetch after reset
          end
        end
        st_decode: state <= st_execute;
        st_execute: state <= st_memory;
        st_memory: state <= st_writeback;
        st_writeback: begin
          state <= st_fetch;
          if (is_halt || illegal) begin
            halted <= 1'b1; // no more requests until reset
          end else begin
            pc <= next_pc;
            imem_req <= 1'b1;
          end
        end
        default: state <= st_fetch;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (state == st_decode) begin
      ir <= imem_rdata;
      rs1_q <= rf.rs1_data;
      rs2_q <= rf.rs2_data;
    end
    if (state == st_execute) begin
      result_q <= result;
    end
  end

  assign fetched = imem_rdata;
  assign instr = ir;

  // decode reads straight from the fetched word
  assign rf.rs1_addr = (state == st_decode) ? fetched.r.rs1 : rs1;
  assign rf.rs2_addr = (state == st_decode) ? fetched.r.rs2 : rs2;

  assign operand_a = is_jal ? pc : (is_lui ? '0 : rs1_q); // jal target via alu
  assign operand_b = use_imm ? imm : rs2_q;
  assign alu_op_sel = alu_op;
  assign br_cond_sel = br_cond;

  // branches get their own adder while the alu compares
  assign pc_plus4 = pc + xlen'(4);
  assign branch_target = pc + imm;
  assign next_pc = is_jal ? result_q : ((is_branch && taken) ? branch_target : pc_plus4);

  assign wb_en = !(is_store || is_branch || is_halt || illegal);
  assign rf.rd_we = (state == st_writeback) && wb_en;
  assign rf.rd_addr = rd;
  assign rf.rd_data = is_load ? dmem_rdata : (is_jal ? pc_plus4 : result_q);

  assign imem_addr = pc;
  assign dmem_addr = result_q;
  assign dmem_wdata = rs2_q;
  assign dmem_re = (state == st_memory) && is_load && !illegal;
  assign dmem_we = (state == st_memory) && is_store && !illegal;

endmodule

`default_nettype wire

//--- design/alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu
  import configure_pkg::*;
  import wires_pkg::*;
(
  input logic [alu_op_width-1:0] alu_op,
  input logic [br_cond_width-1:0] br_cond,
  input logic [xlen-1:0] operand_a,
  input logic [xlen-1:0] operand_b,
  output logic [xlen-1:0] result,
  output logic taken
);

  logic [4:0] shamt;
  logic lt_signed;
  logic lt_unsigned;

  assign shamt = operand_b[4:0];
  assign lt_signed = $signed(operand_a) < $signed(operand_b);
  assign lt_unsigned = operand_a < operand_b;

  always_comb begin
    case (alu_op)
      alu_add: result = operand_a + operand_b;
      alu_sub: result = operand_a - operand_b;
      alu_and: result = operand_a & operand_b;
      alu_or: result = operand_a | operand_b;
      alu_xor: result = operand_a ^ operand_b;
      alu_slt: result = {{(xlen-1){1'b0}}, lt_signed};
      alu_sltu: result = {{(xlen-1){1'b0}}, lt_unsigned};
      alu_sll: result = operand_a << shamt;
      alu_srl: result = operand_a >> shamt;
      alu_sra: result = $unsigned($signed(operand_a) >>> shamt); // sign fill
      alu_pass_b: result = operand_b;
      default: result = '0;
    endcase
  end

  // branch compare, separate from result
  always_comb begin
    case (br_cond)
      br_eq: taken = operand_a == operand_b;
      br_ne: taken = operand_a != operand_b;
      br_lt: taken = lt_signed;
      default: taken = !lt_signed;
    endcase
  end

endmodule

`default_nettype wire

//--- design/decoder.sv
`timescale 1ns/1ps
`default_nettype none

module decoder
  import configure_pkg::*;
  import wires_pkg::*;
(
  input instr_word_t instr,
  output logic [alu_op_width-1:0] alu_op,
  output logic [br_cond_width-1:0] br_cond,
  output logic [xlen-1:0] imm,
  output logic [reg_addr_width-1:0] rs1,
  output logic [reg_addr_width-1:0] rs2,
  output logic [reg_addr_width-1:0] rd,
  output logic is_load,
  output logic is_store,
  output logic is_branch,
  output logic is_jal,
  output logic is_lui,
  output logic use_imm,
  output logic is_halt,
  output logic illegal
);

  logic [xlen-1:0] imm_i;
  logic [xlen-1:0] imm_s;
  logic [xlen-1:0] imm_b;
  logic [xlen-1:0] imm_u;
  logic [xlen-1:0] imm_j;
  logic f7_zero;
  logic f7_alt;
  logic [2:0] funct3;

  assign imm_i = {{20{instr.i.imm[11]}}, instr.i.imm};
  assign imm_s = {{20{instr.s.imm_hi[6]}}, instr.s.imm_hi, instr.s.imm_lo};
  assign imm_b = {{19{instr.b.imm12}}, instr.b.imm12, instr.b.imm11,
                  instr.b.imm10_5, instr.b.imm4_1, 1'b0};
  assign imm_u = {instr.u.imm, 12'b0};
  assign imm_j = {{11{instr.j.imm20}}, instr.j.imm20, instr.j.imm19_12,
                  instr.j.imm11, instr.j.imm10_1, 1'b0};

  assign f7_zero = instr.r.funct7 == 7'b0;
  assign f7_alt = instr.r.funct7 == funct7_alt;
  assign funct3 = instr.r.funct3;

  assign rs1 = instr.r.rs1;
  assign rs2 = instr.r.rs2;
  assign rd = instr.r.rd;

  always_comb begin
    alu_op = alu_add;
    br_cond = br_eq;
    imm = '0;
    is_load = 1'b0;
    is_store = 1'b0;
    is_branch = 1'b0;
    is_jal = 1'b0;
    is_lui = 1'b0;
    use_imm = 1'b0;
    is_halt = 1'b0;
    illegal = 1'b0;
    case (instr.r.opcode)
      op_reg, op_imm: begin
        use_imm = instr.r.opcode == op_imm;
        imm = imm_i;
        case (funct3)
          3'b000: alu_op = (f7_alt && !use_imm) ? alu_sub : alu_add;
          3'b001: alu_op = alu_sll;
          3'b010: alu_op = alu_slt;
          3'b011: alu_op = alu_sltu;
          3'b100: alu_op = alu_xor;
          3'b101: alu_op = f7_alt ? alu_sra : alu_srl;
          3'b110: alu_op = alu_or;
          default: alu_op = alu_and;
        endcase
        // funct7 only matters for shifts, and for every register op
        if (funct3 == 3'b001) begin
          illegal = !f7_zero;
        end else if (funct3 == 3'b101) begin
          illegal = !(f7_zero || f7_alt);
        end else if (!use_imm) begin
          illegal = !(f7_zero || (f7_alt && funct3 == 3'b000));
        end
      end
      op_lui: begin
        is_lui = 1'b1;
        use_imm = 1'b1;
        imm = imm_u;
        alu_op = alu_pass_b;
      end
      op_load: begin
        is_load = 1'b1;
        use_imm = 1'b1;
        imm = imm_i;
        illegal = funct3 != 3'b010; // lw only
      end
      op_store: begin
        is_store = 1'b1;
        use_imm = 1'b1;
        imm = imm_s;
        illegal = funct3 != 3'b010;
      end
      op_branch: begin
        is_branch = 1'b1;
        imm = imm_b;
        alu_op = alu_sub;
        case (funct3)
          3'b000: br_cond = br_eq;
          3'b001: br_cond = br_ne;
          3'b100: br_cond = br_lt;
          3'b101: br_cond = br_ge;
          default: illegal = 1'b1; // no unsigned branches
        endcase
      end
      op_jal: begin
        is_jal = 1'b1;
        use_imm = 1'b1;
        imm = imm_j;
      end
      op_system: begin
        is_halt = instr.raw == instr_ebreak;
        illegal = instr.raw != instr_ebreak;
      end
      default: illegal = 1'b1;
    endcase
  end

endmodule

`default_nettype wire

//--- design/register_file.sv
`timescale 1ns/1ps
`default_nettype none

module register_file
  import configure_pkg::*;
(
  input logic clock,
  input logic reset,
  regfile_if.file rf
);

  logic [xlen-1:0] regs [1:reg_count-1]; // x0 has no storage

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 1; i < reg_count; i++) begin
        regs[i] <= '0;
      end
    end else if (rf.rd_we && rf.rd_addr != '0) begin
      regs[rf.rd_addr] <= rf.rd_data;
    end
  end

  assign rf.rs1_data = (rf.rs1_addr == '0) ? '0 : regs[rf.rs1_addr];
  assign rf.rs2_data = (rf.rs2_addr == '0) ? '0 : regs[rf.rs2_addr];

endmodule

`default_nettype wire

//--- design/regfile_if.sv
`timescale 1ns/1ps
`default_nettype none

interface regfile_if import configure_pkg::*; ();

  logic [reg_addr_width-1:0] rs1_addr;
  logic [reg_addr_width-1:0] rs2_addr;
  logic [xlen-1:0] rs1_data;
  logic [xlen-1:0] rs2_data;
  logic [reg_addr_width-1:0] rd_addr;
  logic [xlen-1:0] rd_data;
  logic rd_we;

  modport file (
    input rs1_addr, rs2_addr, rd_addr, rd_data, rd_we,
    output rs1_data, rs2_data
  );

  modport core (
    output rs1_addr, rs2_addr, rd_addr, rd_data, rd_we,
    input rs1_data, rs2_data
  );

endinterface

`default_nettype wire

//--- design/wires_pkg.sv
`default_nettype none

package wires_pkg;

  // major opcodes
  localparam logic [6:0] op_reg = 7'b0110011;
  localparam logic [6:0] op_imm = 7'b0010011;
  localparam logic [6:0] op_lui = 7'b0110111;
  localparam logic [6:0] op_load = 7'b0000011;
  localparam logic [6:0] op_store = 7'b0100011;
  localparam logic [6:0] op_branch = 7'b1100011;
  localparam logic [6:0] op_jal = 7'b1101111;
  localparam logic [6:0] op_system = 7'b1110011;

  localparam logic [31:0] instr_ebreak = 32'h00100073;
  localparam logic [6:0] funct7_alt = 7'b0100000; // sub, sra, srai

  localparam int alu_op_width = 4;
  localparam logic [alu_op_width-1:0] alu_add = 4'd0;
  localparam logic [alu_op_width-1:0] alu_sub = 4'd1;
  localparam logic [alu_op_width-1:0] alu_and = 4'd2;
  localparam logic [alu_op_width-1:0] alu_or = 4'd3;
  localparam logic [alu_op_width-1:0] alu_xor = 4'd4;
  localparam logic [alu_op_width-1:0] alu_slt = 4'd5;
  localparam logic [alu_op_width-1:0] alu_sltu = 4'd6;
  localparam logic [alu_op_width-1:0] alu_sll = 4'd7;
  localparam logic [alu_op_width-1:0] alu_srl = 4'd8;
  localparam logic [alu_op_width-1:0] alu_sra = 4'd9;
  localparam logic [alu_op_width-1:0] alu_pass_b = 4'd10;

  localparam int br_cond_width = 2;
  localparam logic [br_cond_width-1:0] br_eq = 2'd0;
  localparam logic [br_cond_width-1:0] br_ne = 2'd1;
  localparam logic [br_cond_width-1:0] br_lt = 2'd2;
  localparam logic [br_cond_width-1:0] br_ge = 2'd3;

  // sequencer states
  localparam int state_width = 3;
  localparam logic [state_width-1:0] st_fetch = 3'd0;
  localparam logic [state_width-1:0] st_decode = 3'd1;
  localparam logic [state_width-1:0] st_execute = 3'd2;
  localparam logic [state_width-1:0] st_memory = 3'd3;
  localparam logic [state_width-1:0] st_writeback = 3'd4;

  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } r_view_t;

  typedef struct packed {
    logic [11:0] imm;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } i_view_t;

  typedef struct packed {
    logic [6:0] imm_hi;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] imm_lo;
    logic [6:0] opcode;
  } s_view_t;

  typedef struct packed {
    logic imm12;
    logic [5:0] imm10_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [3:0] imm4_1;
    logic imm11;
    logic [6:0] opcode;
  } b_view_t;

  typedef struct packed {
    logic [19:0] imm;
    logic [4:0] rd;
    logic [6:0] opcode;
  } u_view_t;

  typedef struct packed {
    logic imm20;
    logic [9:0] imm10_1;
    logic imm11;
    logic [7:0] imm19_12;
    logic [4:0] rd;
    logic [6:0] opcode;
  } j_view_t;

  typedef union packed {
    r_view_t r;
    i_view_t i;
    s_view_t s;
    b_view_t b;
    u_view_t u;
    j_view_t j;
    logic [31:0] raw;
  } instr_word_t;

endpackage

`default_nettype wire

//--- design/configure_pkg.sv
`default_nettype none

package configure_pkg;

  // machine size
  localparam int xlen = 32;
  localparam int reg_count = 32;
  localparam int reg_addr_width = 5;

  localparam logic [xlen-1:0] reset_vector = '0; // first fetch address

endpackage

`default_nettype wire
